// File: fpOperandIf.sv
/*
  Unpacked operand pair with format, operation and valid, passed between
  the stages of the sign-injection unit
*/
`timescale 1ns/1ns

interface fpOperandIf import fpPkg::*; ();

  // strobe for the operation held on this bundle
  logic     valid;
  // operand X and operand Y in the wide form
  unpackedT a;
  unpackedT b;
  // requested format and operation
  fmtT      fmt;
  opT       op;

  // producing side
  modport source (output valid, a, b, fmt, op);

  // consuming side
  modport sink (input valid, a, b, fmt, op);

endinterface

// File: fpPkg.sv
/*
  FPU sign-injection package with format widths, format and operation
  codes, and the wide unpacked operand form
*/
package fpPkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // register width
  localparam int FLEN = 64;

  // wide internal form, double layout
  localparam int NE = 11;
  localparam int NF = 52;

  // single precision
  localparam int NE1  = 8;
  localparam int NF1  = 23;
  localparam int LEN1 = 32;

  // half precision
  localparam int NE2  = 5;
  localparam int NF2  = 10;
  localparam int LEN2 = 16;

  ////////////////////////////////////////////////////////////////////////////
  // codes
  ////////////////////////////////////////////////////////////////////////////

  // format code, 3 is reserved
  typedef logic [1:0] fmtT;
  localparam fmtT FMT_S = 2'd0;
  localparam fmtT FMT_D = 2'd1;
  localparam fmtT FMT_H = 2'd2;

  // operation code
  typedef logic [1:0] opT;
  localparam opT OP_SGNJ  = 2'd0;
  localparam opT OP_SGNJN = 2'd1;
  localparam opT OP_SGNJX = 2'd2;
  localparam opT OP_MV    = 2'd3;

  // wide internal form, same bit layout as a double
  typedef struct packed {
    logic          sign;
    logic [NE-1:0] exp;
    logic [NF-1:0] frac;
  } unpackedT;

endpackage

// File: fpSignUnit.sv
/*
  Sign-injection unit top level: unpack, register, inject sign, pack and
  register, two cycles from inValid to outValid
*/
`timescale 1ns/1ns

module fpSignUnit import fpPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            inValid,
  input  fmtT             fmt,
  input  opT              op,
  input  logic [FLEN-1:0] x,
  input  logic [FLEN-1:0] y,
  output logic            outValid,
  output logic [FLEN-1:0] result
);

  // operand bundle held in stage 1
  typedef struct packed {
    unpackedT a;
    unpackedT b;
    fmtT      fmt;
    opT       op;
  } stageT;

  stageT           stageD;
  stageT           stageQ;
  unpackedT        injected;
  logic [FLEN-1:0] packedWord;

  fpOperandIf unpackIf ();
  fpOperandIf stageIf ();

  ////////////////////////////////////////////////////////////////////////////
  // cycle 0, unpack both operands
  ////////////////////////////////////////////////////////////////////////////

  assign unpackIf.valid = inValid;
  assign unpackIf.fmt   = fmt;
  assign unpackIf.op    = op;

  fpUnpack unpackX (.operand(x), .fmt(fmt), .unpacked(unpackIf.a));
  fpUnpack unpackY (.operand(y), .fmt(fmt), .unpacked(unpackIf.b));

  assign stageD = {unpackIf.a, unpackIf.b, unpackIf.fmt, unpackIf.op};

  // stage 1 register
  pipeStage #(.T(stageT)) operandStage (
    .clk(clk), .reset(reset),
    .validIn(unpackIf.valid), .dataIn(stageD),
    .validOut(stageIf.valid), .dataOut(stageQ)
  );

  assign stageIf.a   = stageQ.a;
  assign stageIf.b   = stageQ.b;
  assign stageIf.fmt = stageQ.fmt;
  assign stageIf.op  = stageQ.op;

  ////////////////////////////////////////////////////////////////////////////
  // cycle 1, sign injection and packing
  ////////////////////////////////////////////////////////////////////////////

  signInject inject (.opIn(stageIf.sink), .injected(injected));

  packOutput pack (.unpacked(injected), .fmt(stageIf.fmt), .packedWord(packedWord));

  // stage 2 register drives the outputs
  pipeStage #(.T(logic [FLEN-1:0])) resultStage (
    .clk(clk), .reset(reset),
    .validIn(stageIf.valid), .dataIn(packedWord),
    .validOut(outValid), .dataOut(result)
  );

endmodule

// File: fpSignUnit_assert.sv
/*
  Bound assertions on the sign unit's valid strobes and format code
*/
`timescale 1ns/1ns

module fpSignUnitAssert import fpPkg::*; (
  input logic clk,
  input logic reset,
  input logic inValid,
  input fmtT  fmt,
  input logic outValid
);

  // number of failed assertions
  int failures = 0;

  // no result strobe once reset has been sampled
  resetQuiet: assert property (@(posedge clk) reset |=> !outValid)
    else begin
      $error("result strobe during reset");
      failures++;
    end

  // stage 1 is empty too, so the first cycle after release stays quiet
  releaseQuiet: assert property (@(posedge clk) $fell(reset) |=> !outValid)
    else begin
      $error("result strobe right after reset release");
      failures++;
    end

  // fixed latency of two when no reset was sampled on the way
  latencyTwo: assert property (@(posedge clk) disable iff (reset)
    !$past(reset, 1) && !$past(reset, 2) |-> outValid == $past(inValid, 2))
    else begin
      $error("result strobe does not match input strobe two cycles earlier");
      failures++;
    end

  // code 3 is reserved
  fmtLegal: assert property (@(posedge clk) inValid |-> fmt != 2'd3)
    else begin
      $error("reserved format code with a valid strobe");
      failures++;
    end

endmodule

bind fpSignUnit fpSignUnitAssert checkAssert (.*);

// File: fpUnpack.sv
/*
  Operand unpacker: checks NaN-boxing of single and half values and
  re-encodes the operand into the wide sign, exponent, fraction form
*/
`timescale 1ns/1ns

module fpUnpack import fpPkg::*; (
  input  logic [FLEN-1:0] operand,
  input  fmtT             fmt,
  output unpackedT        unpacked
);

  logic            boxed1;
  logic            boxed2;
  logic [LEN1-1:0] val1;
  logic [LEN2-1:0] val2;
  logic [NE1-1:0]  exp1;
  logic [NE2-1:0]  exp2;

  ////////////////////////////////////////////////////////////////////////////
  // NaN-boxing check
  ////////////////////////////////////////////////////////////////////////////

  // properly boxed when every bit above the format is one
  assign boxed1 = &operand[FLEN-1:LEN1];
  assign boxed2 = &operand[FLEN-1:LEN2];

  // bad boxing turns into the canonical NaN
  // sign 0, exponent all ones, fraction msb set
  assign val1 = boxed1 ? operand[LEN1-1:0]
                       : {1'b0, {NE1{1'b1}}, 1'b1, {(NF1-1){1'b0}}};
  assign val2 = boxed2 ? operand[LEN2-1:0]
                       : {1'b0, {NE2{1'b1}}, 1'b1, {(NF2-1){1'b0}}};

  assign exp1 = val1[LEN1-2:NF1];
  assign exp2 = val2[LEN2-2:NF2];

  ////////////////////////////////////////////////////////////////////////////
  // re-encode into the wide form
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // double passes unchanged, also the reserved code
    unpacked = unpackedT'(operand);
    case (fmt)
      FMT_S: begin
        unpacked.sign = val1[LEN1-1];
        // zero and all-ones exponents keep their pattern
        if (&exp1) begin
          unpacked.exp = '1;
        end else if (~|exp1) begin
          unpacked.exp = '0;
        end else begin
          // keep msb, pad with its inverse, keep low bits
          unpacked.exp = {exp1[NE1-1], {(NE-NE1){~exp1[NE1-1]}}, exp1[NE1-2:0]};
        end
        // fraction left-aligned
        unpacked.frac = {val1[NF1-1:0], {(NF-NF1){1'b0}}};
      end
      FMT_H: begin
        unpacked.sign = val2[LEN2-1];
        if (&exp2) begin
          unpacked.exp = '1;
        end else if (~|exp2) begin
          unpacked.exp = '0;
        end else begin
          unpacked.exp = {exp2[NE2-1], {(NE-NE2){~exp2[NE2-1]}}, exp2[NE2-2:0]};
        end
        unpacked.frac = {val2[NF2-1:0], {(NF-NF2){1'b0}}};
      end
      default: begin
      end
    endcase
  end

endmodule

// File: packOutput.sv
/*
  Result packer: re-encodes the wide form into the requested format and
  NaN-boxes narrow results to the full register width
*/
`timescale 1ns/1ns

module packOutput import fpPkg::*; (
  input  unpackedT        unpacked,
  input  fmtT             fmt,
  output logic [FLEN-1:0] packedWord
);

  logic           sign;
  logic [NE1-1:0] exp1;
  logic [NF1-1:0] fract1;
  logic [NE2-1:0] exp2;
  logic [NF2-1:0] fract2;

  assign sign = unpacked.sign;

  ////////////////////////////////////////////////////////////////////////////
  // narrow fields
  ////////////////////////////////////////////////////////////////////////////

  // exponent keeps the wide msb and the low bits
  // this undoes the widening exactly
  assign exp1   = {unpacked.exp[NE-1], unpacked.exp[NE1-2:0]};
  assign fract1 = unpacked.frac[NF-1:NF-NF1];

  assign exp2   = {unpacked.exp[NE-1], unpacked.exp[NE2-2:0]};
  assign fract2 = unpacked.frac[NF-1:NF-NF2];

  ////////////////////////////////////////////////////////////////////////////
  // format select and boxing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (fmt)
      // single, upper 32 bits all ones
      FMT_S:   packedWord = {{(FLEN-LEN1){1'b1}}, sign, exp1, fract1};
      // half, upper 48 bits all ones
      FMT_H:   packedWord = {{(FLEN-LEN2){1'b1}}, sign, exp2, fract2};
      // double and the reserved code pass through
      default: packedWord = unpacked;
    endcase
  end

endmodule

// File: pipeStage.sv
/*
  Pipeline register for any payload type, with a valid bit
*/
`timescale 1ns/1ns

module pipeStage #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic reset,
  input  logic validIn,
  input  T     dataIn,
  output logic validOut,
  output T     dataOut
);

  // valid follows the strobe, cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      validOut <= 1'b0;
    end else begin
      validOut <= validIn;
    end
  end

  // payload loads every cycle, qualified by validOut downstream
  always_ff @(posedge clk) begin
    dataOut <= dataIn;
  end

endmodule

// File: signInject.sv
/*
  Sign injection: keeps X's exponent and fraction and picks the result
  sign from the operation code and both operand signs
*/
`timescale 1ns/1ns

module signInject import fpPkg::*; (
  fpOperandIf.sink opIn,
  output unpackedT injected
);

  logic signX;
  logic signY;
  logic sign;

  // sign sits at the top of the wide form for every format
  assign signX = opIn.a.sign;
  assign signY = opIn.b.sign;

  ////////////////////////////////////////////////////////////////////////////
  // sign select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (opIn.op)
      // fsgnj, take Y's sign
      OP_SGNJ:  sign = signY;
      // fsgnjn, inverse of Y's sign
      OP_SGNJN: sign = ~signY;
      // fsgnjx, xor of both
      OP_SGNJX: sign = signX ^ signY;
      // fmv keeps X as is
      default:  sign = signX;
    endcase
  end

  // exponent and fraction always come from X
  // a canonical NaN in X carries straight through
  assign injected.sign = sign;
  assign injected.exp  = opIn.a.exp;
  assign injected.frac = opIn.a.frac;

endmodule

// File: sim.f
fpPkg.sv
fpOperandIf.sv
pipeStage.sv
fpUnpack.sv
signInject.sv
packOutput.sv
fpSignUnit.sv
fpSignUnit_assert.sv
tbChecker.sv
tbFpSignUnit.sv

// File: tbChecker.sv
/*
  Result checker: predicts each result from the strobed inputs and
  compares it with the DUT output two cycles later
*/
`timescale 1ns/1ns

module tbChecker import fpPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            inValid,
  input  fmtT             fmt,
  input  opT              op,
  input  logic [FLEN-1:0] x,
  input  logic [FLEN-1:0] y,
  input  logic            outValid,
  input  logic [FLEN-1:0] result,
  input  int              testId,
  output int              mismatches,
  output int              otherErrors,
  output int              pending
);

  // expected value, test id and strobe cycle per operation in flight
  logic [FLEN-1:0] expQ[$];
  int              idQ[$];
  int              cycQ[$];
  int              cycle = 0;
  int              quiet = 0;
  logic            inReset = 1'b0;
  logic [FLEN-1:0] expected;
  int              id;
  int              born;

  function automatic string testName(int n);
    case (n)
      1:       return "double ops";
      2:       return "narrow ops";
      3:       return "bad boxing";
      4:       return "back-to-back";
      default: return "reset burst";
    endcase
  endfunction

  // works on the narrow value directly, len is the format's total width
  function automatic logic [FLEN-1:0] refSign(fmtT f, opT o, logic [FLEN-1:0] a,
                                              logic [FLEN-1:0] b);
    int              len;
    logic [FLEN-1:0] upper;
    logic [FLEN-1:0] canon;
    logic            s;
    len   = (f == FMT_S) ? LEN1 : (f == FMT_H) ? LEN2 : FLEN;
    // bits above the format, empty for double
    upper = {FLEN{1'b1}} << len;
    canon = (f == FMT_S) ? 64'h7fc0_0000 : 64'h7e00;
    // improperly boxed operands become the canonical NaN
    if ((a & upper) != upper) a = canon;
    if ((b & upper) != upper) b = canon;
    case (o)
      OP_SGNJ:  s = b[len-1];
      OP_SGNJN: s = ~b[len-1];
      OP_SGNJX: s = a[len-1] ^ b[len-1];
      default:  s = a[len-1];
    endcase
    a[len-1] = s;
    return upper | a;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare, sampled on the falling edge where everything is stable
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    cycle++;
    if (reset) begin
      // only the first half cycle of reset may still show an old strobe
      if (inReset && outValid !== 1'b0) begin
        $display("error: result strobe while reset is held");
        otherErrors++;
      end
      inReset = 1'b1;
      quiet   = 2;
      expQ.delete();
      idQ.delete();
      cycQ.delete();
    end else begin
      inReset = 1'b0;
      if (quiet > 0) begin
        if (outValid !== 1'b0) begin
          $display("error: result strobe in the cycles right after reset");
          otherErrors++;
        end
        quiet--;
      end else if (outValid) begin
        if (expQ.size() == 0) begin
          $display("error: result strobe with no operation outstanding");
          otherErrors++;
        end else begin
          expected = expQ.pop_front();
          id       = idQ.pop_front();
          born     = cycQ.pop_front();
          if (result !== expected) begin
            $display("FAILED %s: expected %h, actual %h", testName(id), expected, result);
            mismatches++;
          end
          if (cycle - born != 2) begin
            $display("error: result came %0d cycles after its strobe, not 2", cycle - born);
            otherErrors++;
          end
        end
      end
      if (inValid) begin
        expQ.push_back(refSign(fmt, op, x, y));
        idQ.push_back(testId);
        cycQ.push_back(cycle);
      end
    end
    pending = expQ.size();
  end

endmodule

// File: tbFpSignUnit.sv
/*
  Testbench for the sign-injection unit with clock, reset, stimulus for
  each behavior, timeout and the closing report
*/
`timescale 1ns/1ns

module tbFpSignUnit import fpPkg::*; ();

  // 40 double, 40 narrow, 20 bad boxing, 30 back-to-back, 16 reset burst
  localparam int NUM_OPS        = 146;
  localparam int TIMEOUT_CYCLES = 2 * NUM_OPS + 50;

  logic            clk = 1'b0;
  logic            reset;
  logic            inValid;
  fmtT             fmt;
  opT              op;
  logic [FLEN-1:0] x;
  logic [FLEN-1:0] y;
  logic            outValid;
  logic [FLEN-1:0] result;
  int              testId;
  int              mismatches;
  int              otherErrors;
  int              pending;
  int              cycles = 0;
  int              seed = 32'h9ad8;

  // 40 ns period
  always #20 clk = ~clk;

  fpSignUnit uut (.*);

  tbChecker check (.*);

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: %0d results still outstanding after %0d cycles", pending, cycles);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [FLEN-1:0] randWord();
    return {$random(seed), $random(seed)};
  endfunction

  // boxed narrow value where expSel 0 gives a zero exponent, 1 all ones and else random
  function automatic logic [FLEN-1:0] boxedOperand(fmtT f, int expSel);
    logic [FLEN-1:0] w;
    w = randWord();
    if (f == FMT_S) begin
      if (expSel == 0) w[LEN1-2:NF1] = '0;
      if (expSel == 1) w[LEN1-2:NF1] = '1;
      w[FLEN-1:LEN1] = '1;
    end else begin
      if (expSel == 0) w[LEN2-2:NF2] = '0;
      if (expSel == 1) w[LEN2-2:NF2] = '1;
      w[FLEN-1:LEN2] = '1;
    end
    return w;
  endfunction

  // clears one random bit above the narrow format
  function automatic logic [FLEN-1:0] breakBoxing(fmtT f, logic [FLEN-1:0] w);
    int len;
    len = (f == FMT_S) ? LEN1 : LEN2;
    w[len + ({$random(seed)} % (FLEN - len))] = 1'b0;
    return w;
  endfunction

  // operand of any format with one narrow operand in five badly boxed
  function automatic logic [FLEN-1:0] mixedOperand(fmtT f);
    logic [FLEN-1:0] w;
    if (f == FMT_D) return randWord();
    w = boxedOperand(f, {$random(seed)} % 3);
    if ({$random(seed)} % 5 == 0) w = breakBoxing(f, w);
    return w;
  endfunction

  task automatic driveOp(input fmtT f, input opT o, input logic [FLEN-1:0] a,
                         input logic [FLEN-1:0] b);
    @(posedge clk);
    #2;
    inValid = 1'b1;
    fmt     = f;
    op      = o;
    x       = a;
    y       = b;
  endtask

  task automatic idleCycle();
    @(posedge clk);
    #2;
    inValid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int              i;
    fmtT             f;
    logic [FLEN-1:0] a;
    logic [FLEN-1:0] b;
    reset   = 1'b1;
    inValid = 1'b0;
    fmt     = FMT_D;
    op      = OP_MV;
    x       = '0;
    y       = '0;
    testId  = 0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;

    // double with all four ops
    testId = 1;
    for (i = 0; i < 40; i++) begin
      driveOp(FMT_D, opT'(i % 4), randWord(), randWord());
      idleCycle();
    end

    // single and half with zero, all-ones and random exponents
    testId = 2;
    for (i = 0; i < 40; i++) begin
      f = (i % 2 == 0) ? FMT_S : FMT_H;
      driveOp(f, opT'((i / 2) % 4), boxedOperand(f, i % 3), boxedOperand(f, (i / 3) % 3));
      idleCycle();
    end

    // X, Y or both improperly boxed
    testId = 3;
    for (i = 0; i < 20; i++) begin
      f = (i % 2 == 0) ? FMT_S : FMT_H;
      a = boxedOperand(f, 2);
      b = boxedOperand(f, 2);
      if ((i / 4) % 3 != 1) a = breakBoxing(f, a);
      if ((i / 4) % 3 != 0) b = breakBoxing(f, b);
      driveOp(f, opT'(i % 4), a, b);
      idleCycle();
    end

    // strobe every cycle with mixed formats
    testId = 4;
    for (i = 0; i < 30; i++) begin
      f = fmtT'({$random(seed)} % 3);
      driveOp(f, opT'({$random(seed)} % 4), mixedOperand(f), mixedOperand(f));
    end
    idleCycle();

    // reset pulse of two cycles in the middle of a burst
    testId = 5;
    for (i = 0; i < 16; i++) begin
      f = fmtT'({$random(seed)} % 3);
      driveOp(f, opT'({$random(seed)} % 4), mixedOperand(f), mixedOperand(f));
      if (i == 5) reset = 1'b1;
      if (i == 7) reset = 1'b0;
    end
    idleCycle();

    // drain and then a few quiet cycles to catch stray strobes
    while (pending != 0) @(posedge clk);
    repeat (3) @(posedge clk);

    $display("errors: %0d wrong results, %0d other failures, %0d assertion failures",
             mismatches, otherErrors, uut.checkAssert.failures);
    if (mismatches + otherErrors + uut.checkAssert.failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
